// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // matrix rows and SRAM words share one width
    localparam int ROW_W       = 128;
    localparam int MXU_ROWS    = 16;
    localparam int ROW_SEL_W   = 4;

    // on-chip SRAM geometry
    localparam int SRAM_ADDR_W = 8;
    localparam int ORAM_DEPTH  = 2 ** SRAM_ADDR_W;

    // instruction field widths
    localparam int LDST_ADDR_W = 12;
    localparam int DRAM_ADDR_W = 31;
    localparam int NUM_W       = 8;
    localparam int LEN_W       = 3;
    localparam int STR_W       = 3;

    // write channel
    localparam int AW_ADDR_W   = 10;
    localparam int WDATA_W     = 64;
    localparam int BEATS_W     = 5;

    // store target, same coding as the decode stage
    typedef enum logic [1:0] {
        ST_IRAM = 2'b00,
        ST_WRAM = 2'b01,
        ST_ORAM = 2'b10,
        ST_DRAM = 2'b11
    } st_op_t;

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_ADDR,
        DS_READ,
        DS_BEAT
    } dram_state_t;

    // element width in bits, 8 << len
    function automatic logic [7:0] elem_bits(input logic [LEN_W-1:0] len);
        return 8'd8 << len;
    endfunction

    // beats needed to move one 128-bit row
    function automatic logic [BEATS_W-1:0] beats_per_row(input logic [LEN_W-1:0] len);
        return 5'd16 >> len;
    endfunction

    // one element-wide run of ones placed at byte start_x, upper overflow dropped
    function automatic logic [ROW_W-1:0] col_mask(input logic [ROW_SEL_W-1:0] start_x,
                                                  input logic [LEN_W-1:0]     len);
        logic [ROW_W-1:0] run;
        run = {ROW_W{1'b1}} >> (ROW_W - elem_bits(len));
        return run << {start_x, 3'b000};
    endfunction

endpackage

// ==== design/lsu_dispatch.sv ====
`timescale 1ns/1ps

module lsu_dispatch import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_vld,
    input  st_op_t                 instr_op,
    input  logic [DRAM_ADDR_W-1:0] dram_addr,
    input  logic [NUM_W-1:0]       num,
    input  logic [LEN_W-1:0]       len,
    input  logic [STR_W-1:0]       str,
    input  logic [ROW_SEL_W-1:0]   start_x,
    input  logic [ROW_SEL_W-1:0]   start_y,
    input  logic [LDST_ADDR_W-1:0] ldst_addr,
    input  logic                   row_done,
    input  logic                   dram_done,
    output logic                   instr_rdy,
    output logic                   row_start,
    output logic                   dram_start,
    output st_op_t                 op_q,
    output logic [DRAM_ADDR_W-1:0] dram_addr_q,
    output logic [NUM_W-1:0]       num_q,
    output logic [LEN_W-1:0]       len_q,
    output logic [STR_W-1:0]       str_q,
    output logic [ROW_SEL_W-1:0]   start_x_q,
    output logic [ROW_SEL_W-1:0]   start_y_q,
    output logic [SRAM_ADDR_W-1:0] sram_addr_q
);

    logic busy;
    logic accept;

    assign instr_rdy = ~busy;
    assign accept    = instr_vld & instr_rdy;

    // one instruction in flight, released by whichever engine finishes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (row_done | dram_done) begin
            busy <= 1'b0;
        end
    end

    // start pulse one cycle after acceptance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_start  <= 1'b0;
            dram_start <= 1'b0;
        end else begin
            row_start  <= accept & (instr_op != ST_DRAM);
            dram_start <= accept & (instr_op == ST_DRAM);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= instr_op;
            dram_addr_q <= dram_addr;
            num_q       <= num;
            len_q       <= len;
            str_q       <= str;
            start_x_q   <= start_x;
            start_y_q   <= start_y;
            // byte address down to 128-bit word address
            sram_addr_q <= ldst_addr[LDST_ADDR_W-1:4];
        end
    end

endmodule

// ==== design/lsu_row_store.sv ====
`timescale 1ns/1ps

module lsu_row_store import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   row_start,
    input  st_op_t                 op_q,
    input  logic [NUM_W-1:0]       num_q,
    input  logic [LEN_W-1:0]       len_q,
    input  logic [ROW_SEL_W-1:0]   start_x_q,
    input  logic [ROW_SEL_W-1:0]   start_y_q,
    input  logic [SRAM_ADDR_W-1:0] sram_addr_q,
    input  logic [ROW_W-1:0]       mxu_rows [MXU_ROWS],
    input  logic                   mxu_data_rdy,
    output logic                   iram_we,
    output logic [SRAM_ADDR_W-1:0] iram_addr,
    output logic [ROW_W-1:0]       iram_din,
    output logic [ROW_W-1:0]       iram_bwe,
    output logic                   wram_we,
    output logic [SRAM_ADDR_W-1:0] wram_addr,
    output logic [ROW_W-1:0]       wram_din,
    output logic [ROW_W-1:0]       wram_bwe,
    output logic                   oram_we,
    output logic [SRAM_ADDR_W-1:0] oram_waddr,
    output logic [ROW_W-1:0]       oram_din,
    output logic [ROW_W-1:0]       oram_bwe,
    output logic                   row_done
);

    logic                   active;
    logic                   wr_en;
    logic [NUM_W-1:0]       wr_cnt;
    logic [ROW_SEL_W-1:0]   row_idx;
    logic [SRAM_ADDR_W-1:0] wr_addr;
    logic [ROW_W-1:0]       mask;
    logic [ROW_W-1:0]       row_data;

    // a row goes out on every cycle the matrix unit has data
    assign wr_en    = active & mxu_data_rdy;
    assign row_done = wr_en & (wr_cnt == num_q - 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            wr_cnt  <= '0;
            row_idx <= '0;
            wr_addr <= '0;
        end else if (row_start) begin
            active  <= 1'b1;
            wr_cnt  <= '0;
            row_idx <= start_y_q;
            wr_addr <= sram_addr_q;
        end else if (wr_en) begin
            // row index wraps past the last matrix row
            active  <= ~row_done;
            wr_cnt  <= wr_cnt + 1'b1;
            row_idx <= row_idx + 1'b1;
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // column window
    assign mask     = col_mask(start_x_q, len_q);
    assign row_data = mxu_rows[row_idx] & mask;

    // only the selected target sees a write enable
    assign iram_we    = wr_en & (op_q == ST_IRAM);
    assign wram_we    = wr_en & (op_q == ST_WRAM);
    assign oram_we    = wr_en & (op_q == ST_ORAM);

    assign iram_addr  = wr_addr;
    assign iram_din   = row_data;
    assign iram_bwe   = mask;

    assign wram_addr  = wr_addr;
    assign wram_din   = row_data;
    assign wram_bwe   = mask;

    assign oram_waddr = wr_addr;
    assign oram_din   = row_data;
    assign oram_bwe   = mask;

endmodule

// ==== design/lsu_dram_store.sv ====
`timescale 1ns/1ps

module lsu_dram_store import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   dram_start,
    input  logic [DRAM_ADDR_W-1:0] dram_addr_q,
    input  logic [NUM_W-1:0]       num_q,
    input  logic [LEN_W-1:0]       len_q,
    input  logic [STR_W-1:0]       str_q,
    input  logic [SRAM_ADDR_W-1:0] sram_addr_q,
    input  logic [ROW_W-1:0]       oram_rdata,
    input  logic                   awrdy,
    input  logic                   wrdy,
    output logic                   oram_re,
    output logic [SRAM_ADDR_W-1:0] oram_raddr,
    output logic                   awvld,
    output logic [AW_ADDR_W-1:0]   awaddr,
    output logic [NUM_W-1:0]       awlen,
    output logic [LEN_W-1:0]       awsize,
    output logic [STR_W-1:0]       awstr,
    output logic [BEATS_W-1:0]     awnum,
    output logic                   wvld,
    output logic [WDATA_W-1:0]     wdata,
    output logic                   wlast,
    output logic                   dram_done
);

    dram_state_t            state;
    logic [NUM_W-1:0]       row_cnt;
    logic [BEATS_W-1:0]     beat_cnt;
    logic [SRAM_ADDR_W-1:0] rd_addr;
    logic                   load_q;
    logic [ROW_W-1:0]       shift_q;
    logic [ROW_W-1:0]       cur_row;
    logic [WDATA_W-1:0]     beat_mask;
    logic                   beat_acc;
    logic                   last_beat;
    logic                   last_row;

    // address phase fields come straight from the latched instruction
    assign awvld  = (state == DS_ADDR);
    assign awaddr = dram_addr_q[13:4];
    assign awlen  = num_q;
    assign awsize = len_q;
    assign awstr  = str_q;
    assign awnum  = beats_per_row(len_q);

    assign oram_re    = (state == DS_READ);
    assign oram_raddr = rd_addr;

    // fresh oram data on the first beat cycle, shifted copy after that
    assign cur_row   = load_q ? oram_rdata : shift_q;
    assign beat_mask = {WDATA_W{1'b1}} >> (WDATA_W - elem_bits(len_q));

    assign wvld      = (state == DS_BEAT);
    assign wdata     = cur_row[WDATA_W-1:0] & beat_mask;
    assign beat_acc  = wvld & wrdy;
    assign last_beat = (beat_cnt == beats_per_row(len_q) - 1'b1);
    assign last_row  = (row_cnt == num_q - 1'b1);
    assign wlast     = wvld & last_beat & last_row;
    assign dram_done = beat_acc & last_beat & last_row;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DS_IDLE;
            row_cnt  <= '0;
            beat_cnt <= '0;
            rd_addr  <= '0;
        end else begin
            case (state)
                DS_IDLE: begin
                    if (dram_start) begin
                        state    <= DS_ADDR;
                        row_cnt  <= '0;
                        beat_cnt <= '0;
                        rd_addr  <= sram_addr_q;
                    end
                end
                DS_ADDR: begin
                    if (awrdy) begin
                        state <= DS_READ;
                    end
                end
                // single read cycle, data lands next cycle
                DS_READ: begin
                    state <= DS_BEAT;
                end
                DS_BEAT: begin
                    if (beat_acc) begin
                        if (last_beat) begin
                            beat_cnt <= '0;
                            row_cnt  <= row_cnt + 1'b1;
                            rd_addr  <= rd_addr + 1'b1;
                            state    <= last_row ? DS_IDLE : DS_READ;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= (state == DS_READ);
        end
    end

    // next element slides down to bit 0 once a beat is taken
    always_ff @(posedge clk) begin
        if (state == DS_BEAT) begin
            shift_q <= beat_acc ? (cur_row >> elem_bits(len_q)) : cur_row;
        end
    end

endmodule

// ==== design/lsu_oram_bank.sv ====
`timescale 1ns/1ps

module lsu_oram_bank import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   oram_we,
    input  logic [SRAM_ADDR_W-1:0] oram_waddr,
    input  logic [ROW_W-1:0]       oram_din,
    input  logic [ROW_W-1:0]       oram_bwe,
    input  logic                   oram_re,
    input  logic [SRAM_ADDR_W-1:0] oram_raddr,
    output logic [ROW_W-1:0]       oram_rdata
);

    logic [ROW_W-1:0] mem [ORAM_DEPTH];

    // bit-enabled write, untouched bits keep their old value
    always_ff @(posedge clk) begin
        if (oram_we) begin
            mem[oram_waddr] <= (mem[oram_waddr] & ~oram_bwe) | (oram_din & oram_bwe);
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (oram_re) begin
            oram_rdata <= mem[oram_raddr];
        end
    end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,

    // decode stage
    input  logic                   instr_vld,
    input  st_op_t                 instr_op,
    input  logic [DRAM_ADDR_W-1:0] dram_addr,
    input  logic [NUM_W-1:0]       num,
    input  logic [LEN_W-1:0]       len,
    input  logic [STR_W-1:0]       str,
    input  logic [ROW_SEL_W-1:0]   start_x,
    input  logic [ROW_SEL_W-1:0]   start_y,
    input  logic [LDST_ADDR_W-1:0] ldst_addr,
    output logic                   instr_rdy,

    // matrix unit results
    input  logic [ROW_W-1:0]       mxu_rows [MXU_ROWS],
    input  logic                   mxu_data_rdy,

    // external iram and wram macros
    output logic                   iram_we,
    output logic [SRAM_ADDR_W-1:0] iram_addr,
    output logic [ROW_W-1:0]       iram_din,
    output logic [ROW_W-1:0]       iram_bwe,
    output logic                   wram_we,
    output logic [SRAM_ADDR_W-1:0] wram_addr,
    output logic [ROW_W-1:0]       wram_din,
    output logic [ROW_W-1:0]       wram_bwe,

    // AXI write address and data
    input  logic                   awrdy,
    output logic                   awvld,
    output logic [AW_ADDR_W-1:0]   awaddr,
    output logic [NUM_W-1:0]       awlen,
    output logic [LEN_W-1:0]       awsize,
    output logic [STR_W-1:0]       awstr,
    output logic [BEATS_W-1:0]     awnum,
    input  logic                   wrdy,
    output logic                   wvld,
    output logic [WDATA_W-1:0]     wdata,
    output logic                   wlast
);

    logic                   row_start;
    logic                   dram_start;
    logic                   row_done;
    logic                   dram_done;
    st_op_t                 op_q;
    logic [DRAM_ADDR_W-1:0] dram_addr_q;
    logic [NUM_W-1:0]       num_q;
    logic [LEN_W-1:0]       len_q;
    logic [STR_W-1:0]       str_q;
    logic [ROW_SEL_W-1:0]   start_x_q;
    logic [ROW_SEL_W-1:0]   start_y_q;
    logic [SRAM_ADDR_W-1:0] sram_addr_q;

    // oram traffic, writes from the row store and reads for the DRAM store
    logic                   oram_we;
    logic [SRAM_ADDR_W-1:0] oram_waddr;
    logic [ROW_W-1:0]       oram_din;
    logic [ROW_W-1:0]       oram_bwe;
    logic                   oram_re;
    logic [SRAM_ADDR_W-1:0] oram_raddr;
    logic [ROW_W-1:0]       oram_rdata;

    lsu_dispatch i_lsu_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_vld   (instr_vld),
        .instr_op    (instr_op),
        .dram_addr   (dram_addr),
        .num         (num),
        .len         (len),
        .str         (str),
        .start_x     (start_x),
        .start_y     (start_y),
        .ldst_addr   (ldst_addr),
        .row_done    (row_done),
        .dram_done   (dram_done),
        .instr_rdy   (instr_rdy),
        .row_start   (row_start),
        .dram_start  (dram_start),
        .op_q        (op_q),
        .dram_addr_q (dram_addr_q),
        .num_q       (num_q),
        .len_q       (len_q),
        .str_q       (str_q),
        .start_x_q   (start_x_q),
        .start_y_q   (start_y_q),
        .sram_addr_q (sram_addr_q)
    );

    lsu_row_store i_lsu_row_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .row_start    (row_start),
        .op_q         (op_q),
        .num_q        (num_q),
        .len_q        (len_q),
        .start_x_q    (start_x_q),
        .start_y_q    (start_y_q),
        .sram_addr_q  (sram_addr_q),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .iram_we      (iram_we),
        .iram_addr    (iram_addr),
        .iram_din     (iram_din),
        .iram_bwe     (iram_bwe),
        .wram_we      (wram_we),
        .wram_addr    (wram_addr),
        .wram_din     (wram_din),
        .wram_bwe     (wram_bwe),
        .oram_we      (oram_we),
        .oram_waddr   (oram_waddr),
        .oram_din     (oram_din),
        .oram_bwe     (oram_bwe),
        .row_done     (row_done)
    );

    lsu_dram_store i_lsu_dram_store (
        .clk         (clk),
        .arst_n      (arst_n),
        .dram_start  (dram_start),
        .dram_addr_q (dram_addr_q),
        .num_q       (num_q),
        .len_q       (len_q),
        .str_q       (str_q),
        .sram_addr_q (sram_addr_q),
        .oram_rdata  (oram_rdata),
        .awrdy       (awrdy),
        .wrdy        (wrdy),
        .oram_re     (oram_re),
        .oram_raddr  (oram_raddr),
        .awvld       (awvld),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awsize      (awsize),
        .awstr       (awstr),
        .awnum       (awnum),
        .wvld        (wvld),
        .wdata       (wdata),
        .wlast       (wlast),
        .dram_done   (dram_done)
    );

    lsu_oram_bank i_lsu_oram_bank (
        .clk        (clk),
        .oram_we    (oram_we),
        .oram_waddr (oram_waddr),
        .oram_din   (oram_din),
        .oram_bwe   (oram_bwe),
        .oram_re    (oram_re),
        .oram_raddr (oram_raddr),
        .oram_rdata (oram_rdata)
    );

endmodule

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int IRAM_NUM   = 4;
    localparam int WRAM_NUM   = 5;
    localparam int ORAM_NUM   = 6;
    localparam int BUSY_NUM   = 3;
    localparam int LOOP_LIMIT = 400;
    localparam int AW_BITS    = AW_ADDR_W + NUM_W + LEN_W + STR_W + BEATS_W;
    localparam int SRAM_BITS  = SRAM_ADDR_W + 2 * ROW_W;
    // (rows x beats + 20) x 4 summed over every instruction issued
    localparam int WATCHDOG_CYCLES = 4 * (20 + (IRAM_NUM + 20) + (WRAM_NUM + 20)
        + 4 * (ORAM_NUM + 20) + (ORAM_NUM * 4 + 20) + (BUSY_NUM * 16 + 20) + (BUSY_NUM + 20));

    logic                   clk;
    logic                   arst_n;
    logic                   instr_vld;
    st_op_t                 instr_op;
    logic [DRAM_ADDR_W-1:0] dram_addr;
    logic [NUM_W-1:0]       num;
    logic [LEN_W-1:0]       len;
    logic [STR_W-1:0]       str;
    logic [ROW_SEL_W-1:0]   start_x;
    logic [ROW_SEL_W-1:0]   start_y;
    logic [LDST_ADDR_W-1:0] ldst_addr;
    logic                   instr_rdy;
    logic [ROW_W-1:0]       mxu_rows [MXU_ROWS];
    logic                   mxu_data_rdy;
    logic                   iram_we;
    logic [SRAM_ADDR_W-1:0] iram_addr;
    logic [ROW_W-1:0]       iram_din;
    logic [ROW_W-1:0]       iram_bwe;
    logic                   wram_we;
    logic [SRAM_ADDR_W-1:0] wram_addr;
    logic [ROW_W-1:0]       wram_din;
    logic [ROW_W-1:0]       wram_bwe;
    logic                   awrdy;
    logic                   awvld;
    logic [AW_ADDR_W-1:0]   awaddr;
    logic [NUM_W-1:0]       awlen;
    logic [LEN_W-1:0]       awsize;
    logic [STR_W-1:0]       awstr;
    logic [BEATS_W-1:0]     awnum;
    logic                   wrdy;
    logic                   wvld;
    logic [WDATA_W-1:0]     wdata;
    logic                   wlast;

    logic [31:0] lfsr = 32'hb2576ce8;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // instructions of one run issued back to back
    st_op_t                 in_op   [2];
    logic [DRAM_ADDR_W-1:0] in_dram [2];
    logic [NUM_W-1:0]       in_num  [2];
    logic [LEN_W-1:0]       in_len  [2];
    logic [STR_W-1:0]       in_str  [2];
    logic [ROW_SEL_W-1:0]   in_sx   [2];
    logic [ROW_SEL_W-1:0]   in_sy   [2];
    logic [LDST_ADDR_W-1:0] in_ldst [2];

    // reference oram and expected port traffic
    logic [ROW_W-1:0]     oram_model [ORAM_DEPTH];
    logic [SRAM_BITS-1:0] exp_iram [$];
    logic [SRAM_BITS-1:0] exp_wram [$];
    logic [AW_BITS-1:0]   exp_aw [$];
    logic [WDATA_W:0]     exp_beat [$];

    lsu_top i_lsu_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_vld    (instr_vld),
        .instr_op     (instr_op),
        .dram_addr    (dram_addr),
        .num          (num),
        .len          (len),
        .str          (str),
        .start_x      (start_x),
        .start_y      (start_y),
        .ldst_addr    (ldst_addr),
        .instr_rdy    (instr_rdy),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .iram_we      (iram_we),
        .iram_addr    (iram_addr),
        .iram_din     (iram_din),
        .iram_bwe     (iram_bwe),
        .wram_we      (wram_we),
        .wram_addr    (wram_addr),
        .wram_din     (wram_din),
        .wram_bwe     (wram_bwe),
        .awrdy        (awrdy),
        .awvld        (awvld),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awsize       (awsize),
        .awstr        (awstr),
        .awnum        (awnum),
        .wrdy         (wrdy),
        .wvld         (wvld),
        .wdata        (wdata),
        .wlast        (wlast)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // ready about three cycles in four
    function automatic logic rand_ready();
        logic a;
        logic b;
        a = lfsr_bit();
        b = lfsr_bit();
        return a | b;
    endfunction

    // ones from byte sx upward for one element and clipped at the row top
    function automatic logic [ROW_W-1:0] window_mask(input int sx, input int ln);
        logic [ROW_W-1:0] m;
        int i;
        m = '0;
        for (i = sx * 8; i < sx * 8 + 8 * (1 << ln) && i < ROW_W; i++) begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    function automatic logic [WDATA_W-1:0] beat_slice(input logic [ROW_W-1:0] row,
                                                      input int j, input int w);
        logic [WDATA_W-1:0] b;
        int i;
        b = '0;
        for (i = 0; i < w; i++) begin
            b[i] = row[j * w + i];
        end
        return b;
    endfunction

    task automatic check_val(input string name, input string what,
                             input logic [271:0] exp, input logic [271:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic fill_rows();
        int r;
        int b;
        @(posedge clk);
        #2;
        for (r = 0; r < MXU_ROWS; r++) begin
            for (b = 0; b < ROW_W; b++) begin
                mxu_rows[r][b] = lfsr_bit();
            end
        end
    endtask

    // stores the instruction and predicts its traffic from the current rows and oram
    task automatic queue_instr(input int idx, input st_op_t op,
                               input logic [DRAM_ADDR_W-1:0] dram, input int n, input int ln,
                               input int st, input int sx, input int sy,
                               input logic [LDST_ADDR_W-1:0] ldst);
        logic [SRAM_ADDR_W-1:0] addr;
        logic [ROW_W-1:0]       mask;
        logic [ROW_W-1:0]       row;
        logic                   last;
        int beats;
        int k;
        int j;
        in_op[idx]   = op;
        in_dram[idx] = dram;
        in_num[idx]  = n;
        in_len[idx]  = ln;
        in_str[idx]  = st;
        in_sx[idx]   = sx;
        in_sy[idx]   = sy;
        in_ldst[idx] = ldst;
        mask  = window_mask(sx, ln);
        beats = 16 / (1 << ln);
        if (op == ST_DRAM) begin
            exp_aw.push_back({dram[13:4], n[NUM_W-1:0], ln[LEN_W-1:0], st[STR_W-1:0],
                              beats[BEATS_W-1:0]});
            for (k = 0; k < n; k++) begin
                addr = ldst[LDST_ADDR_W-1:4] + k;
                row  = oram_model[addr];
                for (j = 0; j < beats; j++) begin
                    last = (k == n - 1) && (j == beats - 1);
                    exp_beat.push_back({last, beat_slice(row, j, 8 * (1 << ln))});
                end
            end
        end else begin
            for (k = 0; k < n; k++) begin
                addr = ldst[LDST_ADDR_W-1:4] + k;
                row  = mxu_rows[(sy + k) % MXU_ROWS] & mask;
                if (op == ST_IRAM) begin
                    exp_iram.push_back({addr, row, mask});
                end else if (op == ST_WRAM) begin
                    exp_wram.push_back({addr, row, mask});
                end else begin
                    oram_model[addr] = (oram_model[addr] & ~mask) | row;
                end
            end
        end
    endtask

    // values seen here are the ones taken at the next rising edge
    task automatic watch_outputs(input string name);
        if ((iram_we || wram_we) && exp_beat.size() != 0) begin
            $display("%s: SRAM write interleaved with pending DRAM beats", name);
            errors++;
        end
        if (iram_we) begin
            if (exp_iram.size() == 0) begin
                $display("%s: unexpected iram write to address %0h", name, iram_addr);
                errors++;
            end else begin
                check_val(name, "iram write", exp_iram.pop_front(),
                          {iram_addr, iram_din, iram_bwe});
            end
        end
        if (wram_we) begin
            if (exp_wram.size() == 0) begin
                $display("%s: unexpected wram write to address %0h", name, wram_addr);
                errors++;
            end else begin
                check_val(name, "wram write", exp_wram.pop_front(),
                          {wram_addr, wram_din, wram_bwe});
            end
        end
        if (awvld && awrdy) begin
            if (exp_aw.size() == 0) begin
                $display("%s: unexpected write address handshake", name);
                errors++;
            end else begin
                check_val(name, "aw fields", exp_aw.pop_front(),
                          {awaddr, awlen, awsize, awstr, awnum});
            end
        end
        if (wvld && wrdy) begin
            if (exp_beat.size() == 0) begin
                $display("%s: unexpected write data beat %0h", name, wdata);
                errors++;
            end else begin
                check_val(name, "wlast and wdata", exp_beat.pop_front(), {wlast, wdata});
            end
        end
    endtask

    task automatic run_instrs(input string name, input int count);
        int idx;
        int cycles;
        int pending;
        bit finished;
        idx      = 0;
        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #2;
            instr_vld = (idx < count);
            if (idx < count) begin
                instr_op  = in_op[idx];
                dram_addr = in_dram[idx];
                num       = in_num[idx];
                len       = in_len[idx];
                str       = in_str[idx];
                start_x   = in_sx[idx];
                start_y   = in_sy[idx];
                ldst_addr = in_ldst[idx];
            end
            mxu_data_rdy = rand_ready();
            awrdy        = rand_ready();
            wrdy         = rand_ready();
            @(negedge clk);
            // beats still owed before this cycle's edge, the final one included
            pending = exp_beat.size();
            watch_outputs(name);
            if (instr_vld && instr_rdy) begin
                if (idx > 0 && pending != 0) begin
                    $display("%s: instruction %0d accepted before the DRAM store ended",
                             name, idx);
                    errors++;
                end
                idx++;
            end else if (idx == count && instr_rdy) begin
                finished = 1'b1;
            end
            cycles++;
            if (!finished && cycles >= LOOP_LIMIT) begin
                $display("%s: instruction did not complete within %0d cycles", name, cycles);
                errors++;
                finished = 1'b1;
            end
        end
        @(posedge clk);
        #2;
        instr_vld = 1'b0;
        if (exp_iram.size() + exp_wram.size() + exp_aw.size() + exp_beat.size() != 0) begin
            $display("%s: missing %0d iram writes, %0d wram writes, %0d aw, %0d beats", name,
                     exp_iram.size(), exp_wram.size(), exp_aw.size(), exp_beat.size());
            errors++;
        end
        exp_iram.delete();
        exp_wram.delete();
        exp_aw.delete();
        exp_beat.delete();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_val("reset", "rdy awvld wvld wlast iram_we wram_we", 6'b100000,
                  {instr_rdy, awvld, wvld, wlast, iram_we, wram_we});
        report_test("reset", e0);
    endtask

    // start_y 14 wraps the row index
    task automatic store_to_iram();
        int e0;
        e0 = errors;
        fill_rows();
        queue_instr(0, ST_IRAM, '0, IRAM_NUM, 1, 0, 3, 14, 12'h5a0);
        run_instrs("iram_store", 1);
        report_test("iram_store", e0);
    endtask

    task automatic store_to_wram();
        int e0;
        e0 = errors;
        fill_rows();
        queue_instr(0, ST_WRAM, '0, WRAM_NUM, 3, 0, 0, 9, 12'h120);
        run_instrs("wram_store", 1);
        report_test("wram_store", e0);
    endtask

    // four 32-bit windows fill whole oram rows before they go out
    task automatic oram_then_dram();
        int e0;
        int w;
        e0 = errors;
        fill_rows();
        for (w = 0; w < 4; w++) begin
            queue_instr(0, ST_ORAM, '0, ORAM_NUM, 2, 0, w * 4, w * 3, 12'h300);
            run_instrs("oram_fill", 1);
        end
        queue_instr(0, ST_DRAM, 31'h2345_6780, ORAM_NUM, 2, 5, 0, 0, 12'h300);
        run_instrs("dram_store_len2", 1);
        report_test("oram_then_dram", e0);
    endtask

    task automatic busy_holdoff();
        int e0;
        e0 = errors;
        queue_instr(0, ST_DRAM, 31'h0abc_def0, BUSY_NUM, 0, 2, 0, 0, 12'h300);
        queue_instr(1, ST_IRAM, '0, BUSY_NUM, 0, 0, 7, 5, 12'h040);
        run_instrs("busy_holdoff", 2);
        report_test("busy_holdoff", e0);
    endtask

    initial begin
        int r;
        arst_n       = 1'b0;
        instr_vld    = 1'b0;
        instr_op     = ST_IRAM;
        dram_addr    = '0;
        num          = '0;
        len          = '0;
        str          = '0;
        start_x      = '0;
        start_y      = '0;
        ldst_addr    = '0;
        mxu_data_rdy = 1'b0;
        awrdy        = 1'b0;
        wrdy         = 1'b0;
        for (r = 0; r < MXU_ROWS; r++) begin
            mxu_rows[r] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        check_reset_state();
        store_to_iram();
        store_to_wram();
        oram_then_dram();
        busy_holdoff();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
design/lsu_pkg.sv
design/lsu_dispatch.sv
design/lsu_row_store.sv
design/lsu_dram_store.sv
design/lsu_oram_bank.sv
design/lsu_top.sv
test/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_store

sources:
  - design/lsu_pkg.sv
  - design/lsu_dispatch.sv
  - design/lsu_row_store.sv
  - design/lsu_dram_store.sv
  - design/lsu_oram_bank.sv
  - design/lsu_top.sv
  - target: test
    files:
      - test/lsu_tb.sv
